// File: common/noc_macros.svh
// widths must satisfy NOC_DESTW + NOC_SEQW == NOC_DW; NOC_PD must be 1 or more
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// flit data word
`define NOC_DW 16

// destination field at the top of the head flit
`define NOC_DESTW 4

// packet sequence field at the bottom of the head flit
`define NOC_SEQW 12

// default output buffer depth in stages
`define NOC_PD 2

`endif

// File: common/noc_pkg.sv
// head layout is fixed by the macro widths; sequence numbers wrap after 2**NOC_SEQW packets
`default_nettype none

`include "noc_macros.svh"

package noc_pkg;

   // one flit on any hop
   typedef logic [`NOC_DW-1:0] flit_data_t;

   // head flit fields
   typedef logic [`NOC_DESTW-1:0] dest_t;
   typedef logic [`NOC_SEQW-1:0]  seq_t;

   // destination sits in the top bits of the head
   localparam int HEAD_DEST_MSB = `NOC_DW - 1;
   localparam int HEAD_DEST_LSB = `NOC_DW - `NOC_DESTW;

   // sequence number fills the low bits
   localparam int HEAD_SEQ_MSB = `NOC_SEQW - 1;
   localparam int HEAD_SEQ_LSB = 0;

endpackage

`default_nettype wire

// File: outp_buf/outp_buf.sv
// PD >= 1 register stages; i_ack looks through all stages to o_ack combinationally
`default_nettype none
`timescale 1ns/1ps

`include "noc_macros.svh"

module outp_buf #(
   parameter int PD = `NOC_PD   // number of stages
) (
   input  wire                 clk,
   input  wire                 rst_n,
   input  noc_pkg::flit_data_t i_data,
   input  wire                 i_eof,
   input  wire                 i_valid,
   output logic                i_ack,
   output noc_pkg::flit_data_t o_data,
   output logic                o_eof,
   output logic                o_valid,
   input  wire                 o_ack
);

   import noc_pkg::*;

   // chain index PD is the input side, index 0 the output side
   flit_data_t     pd_data [PD:0];
   logic [PD:0]    pd_eof;
   logic [PD:0]    pd_valid;
   logic [PD:0]    pd_ack;   // pd_ack[i] is the ack seen by whatever drives slot i

   // input side
   assign pd_data[PD]  = i_data;
   assign pd_eof[PD]   = i_eof;
   assign pd_valid[PD] = i_valid;
   assign i_ack        = pd_ack[PD];

   // output side
   assign o_data    = pd_data[0];
   assign o_eof     = pd_eof[0];
   assign o_valid   = pd_valid[0];
   assign pd_ack[0] = o_ack;

   genvar i;
   generate
      for (i = 0; i < PD; i++) begin : g_stage
         logic       full;
         flit_data_t data_q;
         logic       eof_q;

         // empty, or the next stage takes our flit this edge
         assign pd_ack[i+1] = !full || pd_ack[i];

         assign pd_valid[i] = full;
         assign pd_data[i]  = data_q;
         assign pd_eof[i]   = eof_q;

         always_ff @(posedge clk) begin
            if (!rst_n)
               full <= 1'b0;
            else if (pd_ack[i+1])
               full <= pd_valid[i+1];   // refill or go empty
         end

         // stage payload
         always_ff @(posedge clk) begin
            if (pd_ack[i+1] && pd_valid[i+1]) begin
               data_q <= pd_data[i+1];
               eof_q  <= pd_eof[i+1];
            end
         end
      end
   endgenerate

endmodule

`default_nettype wire

// File: hw/flit_framer.sv
// every packet needs at least one word; in_dest is only looked at while idle
`default_nettype none
`timescale 1ns/1ps

module flit_framer (
   input  wire                clk,
   input  wire                rst_n,
   input  noc_pkg::flit_data_t in_data,
   input  noc_pkg::dest_t     in_dest,
   input  wire                in_last,
   input  wire                in_valid,
   output logic               in_ack,
   output noc_pkg::flit_data_t f_data,
   output logic               f_eof,
   output logic               f_valid,
   input  wire                f_ack
);

   import noc_pkg::*;

   typedef enum logic {
      ST_HEAD,    // head goes out once the first word shows
      ST_PAYLOAD  // passing words until in_last
   } state_t;

   state_t state;
   seq_t   seq_cnt;   // number of the packet being framed
   seq_t   head_seq;
   logic   load_ok;   // output reg free this cycle
   logic   eof_out;   // last flit leaving on this edge
   logic   head_load;
   logic   word_load;

   assign load_ok = !f_valid || f_ack;
   assign eof_out = f_valid && f_ack && f_eof;

   // counter bumps on the same edge the old eof leaves
   assign head_seq = eof_out ? seq_t'(seq_cnt + 1'b1) : seq_cnt;

   // head cycle never takes a word
   assign in_ack    = (state == ST_PAYLOAD) && load_ok;
   assign head_load = (state == ST_HEAD) && in_valid && load_ok;
   assign word_load = in_valid && in_ack;

   // control
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= ST_HEAD;
         f_valid <= 1'b0;
         seq_cnt <= '0;
      end else begin
         if (eof_out)
            seq_cnt <= seq_cnt + 1'b1;

         if (head_load) begin
            f_valid <= 1'b1;
            state   <= ST_PAYLOAD;
         end else if (word_load) begin
            f_valid <= 1'b1;
            if (in_last)
               state <= ST_HEAD;   // packet closed
         end else if (f_ack) begin
            f_valid <= 1'b0;       // drained with nothing new
         end
      end
   end

   // output flit register
   always_ff @(posedge clk) begin
      if (head_load) begin
         f_data[HEAD_DEST_MSB:HEAD_DEST_LSB] <= in_dest;
         f_data[HEAD_SEQ_MSB:HEAD_SEQ_LSB]   <= head_seq;
         f_eof                               <= 1'b0;   // head never ends a packet
      end else if (word_load) begin
         f_data <= in_data;
         f_eof  <= in_last;
      end
   end

endmodule

`default_nettype wire

// File: hw/pkt_checker.sv
// first flit after reset or after an eof is taken as a head; report fields hold until next head
`default_nettype none
`timescale 1ns/1ps

module pkt_checker (
   input  wire                 clk,
   input  wire                 rst_n,
   input  noc_pkg::flit_data_t b_data,
   input  wire                 b_eof,
   input  wire                 b_valid,
   output logic                b_ack,
   output noc_pkg::flit_data_t link_data,
   output logic                link_eof,
   output logic                link_valid,
   input  wire                 link_ack,
   output logic                pkt_done,
   output noc_pkg::dest_t      pkt_dest,
   output noc_pkg::seq_t       pkt_seq,
   output logic [7:0]          pkt_words,
   output logic [15:0]         pkt_sum
);

   import noc_pkg::*;

   logic in_body;   // head seen and payload pending
   logic xfer;      // flit moves on the link this edge

   // straight pass-through to the link
   assign link_data  = b_data;
   assign link_eof   = b_eof;
   assign link_valid = b_valid;
   assign b_ack      = link_ack;

   assign xfer = link_valid && link_ack;

   // packet framing state and strobe
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_body  <= 1'b0;
         pkt_done <= 1'b0;
      end else begin
         pkt_done <= 1'b0;   // single cycle
         if (xfer) begin
            if (!in_body) begin
               in_body <= 1'b1;
            end else if (link_eof) begin
               in_body  <= 1'b0;   // rearm for next head
               pkt_done <= 1'b1;
            end
         end
      end
   end

   // accounting cleared by every head
   always_ff @(posedge clk) begin
      if (xfer) begin
         if (!in_body) begin
            pkt_dest  <= link_data[HEAD_DEST_MSB:HEAD_DEST_LSB];
            pkt_seq   <= link_data[HEAD_SEQ_MSB:HEAD_SEQ_LSB];
            pkt_words <= '0;
            pkt_sum   <= '0;
         end else begin
            pkt_words <= pkt_words + 1'b1;   // wraps past 255 words
            pkt_sum   <= pkt_sum + link_data;   // modulo 2**16
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/noc_out_port.sv
// output port only; no routing or arbitration, link_ack is the sole back-pressure source
`default_nettype none
`timescale 1ns/1ps

`include "noc_macros.svh"

module noc_out_port (
   input  wire                 clk,
   input  wire                 rst_n,
   input  noc_pkg::flit_data_t in_data,
   input  noc_pkg::dest_t      in_dest,
   input  wire                 in_last,
   input  wire                 in_valid,
   output logic                in_ack,
   output noc_pkg::flit_data_t link_data,
   output logic                link_eof,
   output logic                link_valid,
   input  wire                 link_ack,
   output logic                pkt_done,
   output noc_pkg::dest_t      pkt_dest,
   output noc_pkg::seq_t       pkt_seq,
   output logic [7:0]          pkt_words,
   output logic [15:0]         pkt_sum
);

   import noc_pkg::*;

   // framer to buffer
   flit_data_t f_data;
   logic       f_eof;
   logic       f_valid;
   logic       f_ack;

   // buffer to checker
   flit_data_t b_data;
   logic       b_eof;
   logic       b_valid;
   logic       b_ack;

   flit_framer framer_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_data  (in_data),
      .in_dest  (in_dest),
      .in_last  (in_last),
      .in_valid (in_valid),
      .in_ack   (in_ack),
      .f_data   (f_data),
      .f_eof    (f_eof),
      .f_valid  (f_valid),
      .f_ack    (f_ack)
   );

   outp_buf #(.PD(`NOC_PD)) buf_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .i_data  (f_data),
      .i_eof   (f_eof),
      .i_valid (f_valid),
      .i_ack   (f_ack),
      .o_data  (b_data),
      .o_eof   (b_eof),
      .o_valid (b_valid),
      .o_ack   (b_ack)
   );

   pkt_checker checker_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .b_data     (b_data),
      .b_eof      (b_eof),
      .b_valid    (b_valid),
      .b_ack      (b_ack),
      .link_data  (link_data),
      .link_eof   (link_eof),
      .link_valid (link_valid),
      .link_ack   (link_ack),
      .pkt_done   (pkt_done),
      .pkt_dest   (pkt_dest),
      .pkt_seq    (pkt_seq),
      .pkt_words  (pkt_words),
      .pkt_sum    (pkt_sum)
   );

endmodule

`default_nettype wire

// File: dv/noc_out_port_tb.sv
// run from the project root; golden file holds at most 64 words and 16 reports
`default_nettype none
`timescale 1ns/1ps

module noc_out_port_tb;

   import noc_pkg::*;

   logic        clk = 1'b0;
   logic        rst_n = 1'b0;
   flit_data_t  in_data = '0;
   dest_t       in_dest = '0;
   logic        in_last = 1'b0;
   logic        in_valid = 1'b0;
   logic        link_ack = 1'b0;
   logic        in_ack, link_eof, link_valid, pkt_done;
   flit_data_t  link_data;
   dest_t       pkt_dest;
   seq_t        pkt_seq;
   logic [7:0]  pkt_words;
   logic [15:0] pkt_sum;

   dest_t       w_dest [64];   // input words
   flit_data_t  w_data [64];
   logic        w_last [64];
   dest_t       p_dest [16];   // expected reports
   seq_t        p_seq [16];
   logic [7:0]  p_words [16];
   logic [15:0] p_sum [16];
   flit_data_t  exp_data [$];  // flits the link should carry in order
   logic        exp_eof [$];
   int          n_words = 0;
   int          n_pkts = 0;
   int          acked = 0;
   int          rep_cnt = 0;
   int          mism_cnt = 0;
   int          other_cnt = 0;
   int          cyc = 0;
   int          limit = 0;
   int          stall_left = 0;
   integer      seed = 32'h0a7e5964;
   logic        seen_valid = 1'b0;   // first word offered
   logic        hold_pending = 1'b0; // link stalled on last edge
   flit_data_t  held_data;
   logic        held_eof;

   noc_out_port dut_i (.*);

   always #20 clk = ~clk;   // 40 ns period

   task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("Mismatch at %0d ns: %s expected %h, got %h", $time, sig, exp, got);
      mism_cnt++;
   endtask

   task automatic report_error(input string what);
      $display("Error at %0d ns: %s", $time, what);
      other_cnt++;
   endtask

   // reads words and reports and builds the link model on the way
   task automatic load_golden;
      integer fd, n;
      logic [7:0] tag;
      logic [31:0] a, b, c, d;
      string rest;
      int pkt;
      logic new_pkt;
      pkt = 0;
      new_pkt = 1'b1;
      fd = $fopen("dv/noc_out_port_golden.txt", "r");
      if (fd == 0) begin
         report_error("cannot open dv/noc_out_port_golden.txt");
         return;
      end
      while (!$feof(fd)) begin
         n = $fscanf(fd, " %c", tag);
         if (n != 1)
            break;
         if (tag == "W" && n_words < 64) begin
            n = $fscanf(fd, "%h %h %h", a, b, c);
            w_dest[n_words] = a[3:0];
            w_data[n_words] = b[15:0];
            w_last[n_words] = c[0];
            if (new_pkt) begin   // head is dest on top with the packet index below
               exp_data.push_back({a[3:0], seq_t'(pkt)});
               exp_eof.push_back(1'b0);
               pkt++;
            end
            exp_data.push_back(b[15:0]);
            exp_eof.push_back(c[0]);
            new_pkt = c[0];
            n_words++;
         end else if (tag == "P" && n_pkts < 16) begin
            n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
            p_dest[n_pkts]  = a[3:0];
            p_seq[n_pkts]   = b[11:0];
            p_words[n_pkts] = c[7:0];
            p_sum[n_pkts]   = d[15:0];
            n_pkts++;
         end else begin
            n = $fgets(rest, fd);   // comment line
         end
      end
      $fclose(fd);
   endtask

   // random link back-pressure with ack high about 3 cycles in 4 and some 8-cycle stalls
   always @(posedge clk) begin : link_stall
      integer r;
      if (stall_left > 0) begin
         link_ack <= 1'b0;
         stall_left = stall_left - 1;
      end else begin
         r = $random(seed);
         if (r[3:0] == 4'd0) begin
            link_ack <= 1'b0;
            stall_left = 7;
         end else
            link_ack <= (r[9:8] != 2'b00);
      end
   end

   // link and report monitor on pre-edge values
   always @(posedge clk) begin : monitor
      flit_data_t ed;
      logic ee;
      cyc <= cyc + 1;
      if (!rst_n) begin
         if (cyc >= 1)
            assert (!in_ack) else report_error("in_ack high during reset");
      end else begin
         if (!seen_valid)
            assert (!link_valid && !pkt_done) else report_error("link active before any input");
         seen_valid = seen_valid || in_valid;
         if (hold_pending) begin   // stalled flit must stay put
            assert (link_valid) else report_error("link_valid dropped while link_ack low");
            assert (link_data == held_data)
               else report_mismatch("link_data", held_data, link_data);
            assert (link_eof == held_eof) else report_mismatch("link_eof", held_eof, link_eof);
         end
         if (link_valid && link_ack) begin
            assert (exp_data.size() > 0)
               else report_error("flit on the link beyond the expected stream");
            if (exp_data.size() > 0) begin
               ed = exp_data.pop_front();
               ee = exp_eof.pop_front();
               assert (link_data == ed) else report_mismatch("link_data", ed, link_data);
               assert (link_eof == ee) else report_mismatch("link_eof", ee, link_eof);
            end
         end
         hold_pending = link_valid && !link_ack;
         held_data = link_data;
         held_eof = link_eof;
         if (pkt_done) begin
            assert (rep_cnt < n_pkts)
               else report_error("more packet reports than packets in the golden file");
            if (rep_cnt < n_pkts) begin
               assert (pkt_dest == p_dest[rep_cnt])
                  else report_mismatch("pkt_dest", p_dest[rep_cnt], pkt_dest);
               assert (pkt_seq == p_seq[rep_cnt])
                  else report_mismatch("pkt_seq", p_seq[rep_cnt], pkt_seq);
               assert (pkt_words == p_words[rep_cnt])
                  else report_mismatch("pkt_words", p_words[rep_cnt], pkt_words);
               assert (pkt_sum == p_sum[rep_cnt])
                  else report_mismatch("pkt_sum", p_sum[rep_cnt], pkt_sum);
            end
            rep_cnt++;
         end
      end
   end

   initial begin : main
      int k;
      load_golden();
      assert (n_pkts > 0) else report_error("golden file holds no packet reports");
      limit = 200 * n_words;   // cycle budget
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      repeat (4) @(posedge clk);   // idle link before the first word
      for (k = 0; k < n_words && cyc < limit; k++) begin
         in_data  <= w_data[k];
         in_dest  <= w_dest[k];
         in_last  <= w_last[k];
         in_valid <= 1'b1;
         @(posedge clk);
         while (!in_ack && cyc < limit)
            @(posedge clk);
         if (in_ack)
            acked++;
      end
      in_valid <= 1'b0;
      while (rep_cnt < n_pkts && cyc < limit)
         @(negedge clk);
      if (cyc >= limit)
         report_error($sformatf("timeout after %0d cycles", cyc));
      else
         repeat (40) @(posedge clk);   // no further flit or report may show up
      assert (acked == n_words) else report_error("not every input word was acknowledged");
      assert (rep_cnt == n_pkts) else report_error("packet report count differs from golden file");
      assert (exp_data.size() == 0) else report_error("expected flits never reached the link");
      $display("errors: %0d mismatches, %0d other", mism_cnt, other_cnt);
      if (mism_cnt == 0 && other_cnt == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/noc_out_port_golden.txt
# W dest data last : one input word in hex, last=1 closes the packet
# P dest seq words sum : expected report for that packet in hex
W 3 1234 0
W 3 0001 0
W 3 00ff 1
P 3 000 03 1334
W a beef 1
P a 001 01 beef
W 5 0010 0
W 5 0020 0
W 5 0030 0
W 5 0040 0
W 5 0050 1
P 5 002 05 00f0
W f ffff 0
W f 0002 1
P f 003 02 0001
W 0 a5a5 0
W 0 5a5a 0
W 0 1111 0
W 0 2222 1
P 0 004 04 3332
W 7 8000 0
W 7 8000 0
W 7 0abc 0
W 7 0def 0
W 7 0123 1
P 7 005 05 19ce

// File: build.f
+incdir+common
common/noc_pkg.sv
outp_buf/outp_buf.sv
hw/flit_framer.sv
hw/pkt_checker.sv
hw/noc_out_port.sv
dv/noc_out_port_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --timescale 1ns/1ps -f build.f \
   --top-module noc_out_port_tb -o noc_out_port_sim \
   && ./obj_dir/noc_out_port_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -qx '\*\*\* PASSED \*\*\*' sim.log && echo "result: pass" \
   || { echo "result: fail"; exit 1; }
